//--- list.f
source/adc_scan_pkg.sv
source/adc_spi_frame.sv
source/adc_channel_sequencer.sv
source/adc_result_bank.sv
source/adc_scan_top.sv
test/adc_model.sv
test/tb_adc_scan.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the simulation ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_adc_scan -f list.f -Mdir obj_dir -o sim_adc_scan

./obj_dir/sim_adc_scan

//--- source/adc_channel_sequencer.sv
`timescale 1ns/100ps

module adc_channel_sequencer
#(
	parameter int NUM_CHANNELS = 7
)
(
	input  logic                                  c1m,
	input  logic                                  rst_n,
	input  logic                                  frame_done,
	input  logic [adc_scan_pkg::sample_width-1:0] frame_sample,
	output logic [adc_scan_pkg::chan_width-1:0]   addr_channel,
	output logic                                  wr_en,
	output logic [adc_scan_pkg::chan_width-1:0]   wr_channel,
	output logic [adc_scan_pkg::sample_width-1:0] wr_data
);

	localparam logic [adc_scan_pkg::chan_width-1:0] last_channel =
		adc_scan_pkg::chan_width'(NUM_CHANNELS - 1);

	logic [adc_scan_pkg::chan_width-1:0] prev_channel;
	logic                                first_frame;

	always_ff @(posedge c1m or negedge rst_n)
	begin
		if (!rst_n)
		begin
			addr_channel <= '0;
			prev_channel <= '0;
			first_frame  <= 1'b1;
			wr_en        <= 1'b0;
		end
		else
		begin
			wr_en <= frame_done && !first_frame;  // First frame returns no addressed data.
			if (frame_done)
			begin
				prev_channel <= addr_channel;
				first_frame  <= 1'b0;
				if (addr_channel == last_channel)
					addr_channel <= '0;
				else
					addr_channel <= addr_channel + 1'b1;
			end
		end
	end

	// The sample of this frame belongs to the address sent one frame earlier.
	always_ff @(posedge c1m)
	begin
		if (frame_done)
		begin
			wr_channel <= prev_channel;
			wr_data    <= frame_sample;
		end
	end

endmodule

//--- source/adc_result_bank.sv
`timescale 1ns/100ps

module adc_result_bank
#(
	parameter int NUM_CHANNELS = 7
)
(
	input  logic                                  c1m,
	input  logic                                  rst_n,
	input  logic                                  wr_en,
	input  logic [adc_scan_pkg::chan_width-1:0]   wr_channel,
	input  logic [adc_scan_pkg::sample_width-1:0] wr_data,
	input  logic                                  rd_req,
	input  logic [adc_scan_pkg::chan_width-1:0]   rd_channel,
	output logic                                  rd_ack,
	output logic [adc_scan_pkg::sample_width-1:0] rd_data,
	output logic                                  rd_fresh
);

	logic [adc_scan_pkg::sample_width-1:0] samples [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0]               fresh;
	logic                                  rd_hit;
	logic                                  wr_hit;

	assign rd_hit = int'(rd_channel) < NUM_CHANNELS;
	assign wr_hit = int'(wr_channel) < NUM_CHANNELS;

	always_ff @(posedge c1m or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_ack   <= 1'b0;
			rd_data  <= '0;
			rd_fresh <= 1'b0;
			fresh    <= '0;
			for (int i = 0; i < NUM_CHANNELS; i++)
				samples[i] <= '0;
		end
		else
		begin
			if (!rd_ack && rd_req)
			begin
				rd_ack <= 1'b1;
				if (rd_hit)
				begin
					rd_data           <= samples[rd_channel];  // Old value on a same-cycle write.
					rd_fresh          <= fresh[rd_channel];
					fresh[rd_channel] <= 1'b0;
				end
				else
				begin
					rd_data  <= '0;
					rd_fresh <= 1'b0;
				end
			end
			else if (rd_ack && !rd_req)
				rd_ack <= 1'b0;

			// Placed after the read so a new sample keeps its fresh flag.
			if (wr_en && wr_hit)
			begin
				samples[wr_channel] <= wr_data;
				fresh[wr_channel]   <= 1'b1;
			end
		end
	end

endmodule

//--- source/adc_scan_pkg.sv
package adc_scan_pkg;

	// ADC result bits per conversion.
	localparam int sample_width = 12;

	// Channel address width on the wire and on the host port.
	localparam int chan_width = 3;

	localparam int frame_clocks = 16;     // Serial clocks per frame.
	localparam int addr_first_clock = 2;  // Clock that carries the address MSB.
	localparam int data_first_clock = 4;  // Clock that carries sample bit 11.
	localparam int cs_idle_cycles = 2;    // Cycles with cs_n high between frames.

	// Each serial clock takes two c1m cycles, so one frame period is idle plus 32.
	localparam int frame_period = cs_idle_cycles + 2 * frame_clocks;
	localparam int frame_cnt_width = $clog2(frame_period);

endpackage

//--- source/adc_scan_top.sv
`timescale 1ns/100ps

module adc_scan_top
#(
	parameter int NUM_CHANNELS = 7
)
(
	input  logic                                  c1m,
	input  logic                                  rst_n,
	input  logic                                  dout,
	output logic                                  sclk,
	output logic                                  cs_n,
	output logic                                  din,
	input  logic                                  rd_req,
	input  logic [adc_scan_pkg::chan_width-1:0]   rd_channel,
	output logic                                  rd_ack,
	output logic [adc_scan_pkg::sample_width-1:0] rd_data,
	output logic                                  rd_fresh
);

	logic [adc_scan_pkg::chan_width-1:0]   addr_channel;
	logic                                  frame_done;
	logic [adc_scan_pkg::sample_width-1:0] frame_sample;
	logic                                  wr_en;
	logic [adc_scan_pkg::chan_width-1:0]   wr_channel;
	logic [adc_scan_pkg::sample_width-1:0] wr_data;

	adc_spi_frame adc_spi_frame_i (
		.c1m          (c1m),
		.rst_n        (rst_n),
		.dout         (dout),
		.addr_channel (addr_channel),
		.sclk         (sclk),
		.cs_n         (cs_n),
		.din          (din),
		.frame_done   (frame_done),
		.frame_sample (frame_sample)
	);

	adc_channel_sequencer #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) adc_channel_sequencer_i (
		.c1m          (c1m),
		.rst_n        (rst_n),
		.frame_done   (frame_done),
		.frame_sample (frame_sample),
		.addr_channel (addr_channel),
		.wr_en        (wr_en),
		.wr_channel   (wr_channel),
		.wr_data      (wr_data)
	);

	adc_result_bank #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) adc_result_bank_i (
		.c1m        (c1m),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_channel (wr_channel),
		.wr_data    (wr_data),
		.rd_req     (rd_req),
		.rd_channel (rd_channel),
		.rd_ack     (rd_ack),
		.rd_data    (rd_data),
		.rd_fresh   (rd_fresh)
	);

endmodule

//--- source/adc_spi_frame.sv
`timescale 1ns/100ps

module adc_spi_frame
(
	input  logic                                  c1m,
	input  logic                                  rst_n,
	input  logic                                  dout,
	input  logic [adc_scan_pkg::chan_width-1:0]   addr_channel,
	output logic                                  sclk,
	output logic                                  cs_n,
	output logic                                  din,
	output logic                                  frame_done,
	output logic [adc_scan_pkg::sample_width-1:0] frame_sample
);

	localparam int cw = adc_scan_pkg::frame_cnt_width;
	localparam logic [cw-1:0] idle = cw'(adc_scan_pkg::cs_idle_cycles);
	localparam logic [cw-1:0] last = cw'(adc_scan_pkg::frame_period - 1);
	localparam logic [cw-2:0] addr_lo = (cw-1)'(adc_scan_pkg::addr_first_clock);
	localparam logic [cw-2:0] addr_hi =
		(cw-1)'(adc_scan_pkg::addr_first_clock + adc_scan_pkg::chan_width - 1);
	localparam logic [cw-2:0] data_lo = (cw-1)'(adc_scan_pkg::data_first_clock);

	logic [cw-1:0] cnt;
	logic [cw-1:0] cnt_nxt;
	logic [cw-1:0] half_cur;  // Half-clock index inside the frame.
	logic [cw-1:0] half_nxt;
	logic          addr_clock_nxt;
	logic          addr_load_nxt;
	logic          capture;
	logic [adc_scan_pkg::chan_width-1:0] addr_sh;

	always_comb
	begin
		if (cnt == last)
			cnt_nxt = '0;
		else
			cnt_nxt = cnt + 1'b1;
		half_cur = cnt - idle;
		half_nxt = cnt_nxt - idle;
		addr_clock_nxt = (cnt_nxt >= idle) && (half_nxt[cw-1:1] >= addr_lo) &&
			(half_nxt[cw-1:1] <= addr_hi);
		addr_load_nxt = addr_clock_nxt && !half_nxt[0];  // Low half of an address clock.
		// The cycle before sclk rises on a data clock.
		capture = (cnt >= idle) && !half_cur[0] && (half_cur[cw-1:1] >= data_lo);
	end

	always_ff @(posedge c1m or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt        <= '0;
			cs_n       <= 1'b1;
			sclk       <= 1'b0;
			din        <= 1'b0;
			frame_done <= 1'b0;
			addr_sh    <= '0;
		end
		else
		begin
			cnt        <= cnt_nxt;
			cs_n       <= cnt_nxt < idle;
			sclk       <= (cnt_nxt >= idle) && half_nxt[0];
			frame_done <= cnt == last;  // Follows the final falling sclk edge.
			if (cnt_nxt == idle)
				addr_sh <= addr_channel;  // Address held for the whole frame.
			if (addr_load_nxt)
			begin
				din     <= addr_sh[adc_scan_pkg::chan_width-1];
				addr_sh <= addr_sh << 1;
			end
			else if (!addr_clock_nxt)
				din <= 1'b0;
		end
	end

	// dout was set up on the previous falling edge, MSB arrives first.
	always_ff @(posedge c1m)
	begin
		if (capture)
			frame_sample <= {frame_sample[adc_scan_pkg::sample_width-2:0], dout};
	end

endmodule

//--- test/adc_model.sv
`timescale 1ns/100ps

module adc_model
(
	input  logic             sclk,
	input  logic             cs_n,
	input  logic             din,
	input  logic [7:0][11:0] values,
	output logic             dout
);

	logic [2:0]  addr_sh = 3'd0;
	logic [2:0]  next_addr = 3'd0;
	logic        addr_known = 1'b0;
	logic [11:0] out_sh = 12'h000;
	logic        sclk_q = 1'b0;
	logic        bit_out = 1'b0;
	int          rise_idx = 0;
	int          fall_idx = 0;
	logic [2:0]  addr_log [256];
	int          addr_count = 0;

	assign dout = bit_out;

	always @(negedge cs_n or posedge sclk or negedge sclk)
	begin
		if (sclk == sclk_q)
		begin
			// Chip select fell. The previous frame's address selects what goes out now.
			rise_idx = 0;
			fall_idx = 0;
			out_sh = addr_known ? values[next_addr] : 12'h000;
		end
		else if (sclk)
		begin
			if (rise_idx >= 2 && rise_idx <= 4)
				addr_sh = {addr_sh[1:0], din};  // Address MSB comes first.
			if (rise_idx == 4)
			begin
				next_addr = addr_sh;
				addr_known = 1'b1;
				if (addr_count < 256)
					addr_log[addr_count] = addr_sh;
				addr_count++;
			end
			rise_idx++;
		end
		else
		begin
			// Bit 11 goes out on the falling edge ahead of the fifth serial clock.
			if (fall_idx >= 3 && fall_idx <= 14)
				bit_out = out_sh[14 - fall_idx];
			else
				bit_out = 1'b0;
			fall_idx++;
		end
		sclk_q = sclk;
	end

endmodule

//--- test/tb_adc_scan.sv
`timescale 1ns/100ps

module tb_adc_scan;

	localparam int NUM_CHANNELS = 7;
	localparam int clock_period = 8;
	localparam int frame_period = 34;  // Two idle cycles and 16 serial clocks of two cycles.
	localparam int latency_cycles = (NUM_CHANNELS + 1) * frame_period + 2;
	localparam int watchdog_ns = 3 * 9 * frame_period * clock_period + 1000;
	localparam int num_ops = 31;

	logic        c1m;
	logic        rst_n;
	logic        dout;
	logic        sclk;
	logic        cs_n;
	logic        din;
	logic        rd_req;
	logic [2:0]  rd_channel;
	logic        rd_ack;
	logic [11:0] rd_data;
	logic        rd_fresh;

	logic [7:0][11:0] model_values;
	logic [11:0]      sample_table [2][NUM_CHANNELS];
	int               op_phase [num_ops];
	logic [2:0]       op_channel [num_ops];
	logic [11:0]      op_data [num_ops];
	logic             op_fresh [num_ops];
	int               op_count;
	integer           seed;

	adc_scan_top #(
		.NUM_CHANNELS (NUM_CHANNELS)
	) adc_scan_top_i (
		.c1m        (c1m),
		.rst_n      (rst_n),
		.dout       (dout),
		.sclk       (sclk),
		.cs_n       (cs_n),
		.din        (din),
		.rd_req     (rd_req),
		.rd_channel (rd_channel),
		.rd_ack     (rd_ack),
		.rd_data    (rd_data),
		.rd_fresh   (rd_fresh)
	);

	adc_model adc_model_i (
		.sclk   (sclk),
		.cs_n   (cs_n),
		.din    (din),
		.values (model_values),
		.dout   (dout)
	);

	task automatic end_with_failure();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at time %0t: %s", $time, msg);
		end_with_failure();
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		end_with_failure();
	endtask

	function automatic void add_read(input int phase, input int channel,
		input logic [11:0] data, input logic fresh);
		op_phase[op_count]   = phase;
		op_channel[op_count] = 3'(channel);
		op_data[op_count]    = data;
		op_fresh[op_count]   = fresh;
		op_count++;
	endfunction

	function automatic void build_tables();
		seed = 32'h46a1;
		for (int r = 0; r < 2; r++)
			for (int c = 0; c < NUM_CHANNELS; c++)
				sample_table[r][c] = 12'($random(seed));
		op_count = 0;
		for (int c = 0; c < 8; c++)
			add_read(0, c, 12'h000, 1'b0);  // Nothing converted yet.
		for (int c = 0; c < NUM_CHANNELS; c++)
		begin
			add_read(1, c, sample_table[0][c], 1'b1);
			add_read(1, c, sample_table[0][c], 1'b0);  // The ack cleared the flag.
		end
		add_read(1, 7, 12'h000, 1'b0);
		for (int c = 0; c < NUM_CHANNELS; c++)
			add_read(2, c, sample_table[1][c], 1'b1);
		add_read(2, 7, 12'h000, 1'b0);
	endfunction

	task automatic load_round(input int round);
		for (int c = 0; c < 8; c++)
		begin
			if (c < NUM_CHANNELS)
				model_values[c] = sample_table[round][c];
			else
				model_values[c] = 12'h000;
		end
	endtask

	// Phases start at a frame end so that writes land at known cycles.
	task automatic start_phase(input int phase);
		@(posedge cs_n);
		#1;
		if (phase == 2)
			load_round(1);
		repeat (latency_cycles) @(posedge c1m);
		#1;
	endtask

	task automatic host_read(input logic [2:0] channel, output logic [11:0] data,
		output logic fresh);
		int wait_cycles;
		wait_cycles = 0;
		rd_channel = channel;
		rd_req = 1'b1;
		@(posedge c1m);
		#1;
		while (!rd_ack && wait_cycles < 8)
		begin
			@(posedge c1m);
			#1;
			wait_cycles++;
		end
		assert (rd_ack)
		else
			report_problem($sformatf("rd_ack never rose for channel %0d", channel));
		data = rd_data;
		fresh = rd_fresh;
		rd_req = 1'b0;
		@(posedge c1m);
		#1;
		assert (!rd_ack)
		else
			report_problem("rd_ack stayed high one cycle after rd_req dropped");
	endtask

	task automatic check_address_order();
		int count;
		count = adc_model_i.addr_count;
		assert (count >= 2 * NUM_CHANNELS)
		else
			report_problem("the ADC saw fewer frames than two full scans");
		for (int i = 0; i < count && i < 256; i++)
		begin
			assert (adc_model_i.addr_log[i] == 3'(i % NUM_CHANNELS))
			else
				report_mismatch($sformatf("frame %0d addressed channel %0d, expected %0d",
					i, adc_model_i.addr_log[i], i % NUM_CHANNELS));
		end
	endtask

	initial
	begin
		c1m = 1'b0;
		forever #(clock_period / 2) c1m = ~c1m;
	end

	initial
	begin
		#(watchdog_ns);
		report_problem("timeout, the test did not finish in the expected time");
	end

	initial
	begin
		logic [11:0] got_data;
		logic        got_fresh;
		int          phase;
		rst_n = 1'b0;
		rd_req = 1'b0;
		rd_channel = 3'd0;
		build_tables();
		load_round(0);
		repeat (4) @(posedge c1m);
		#1;
		rst_n = 1'b1;
		assert (cs_n && !sclk && !din && !rd_ack)
		else
			report_mismatch($sformatf("after reset cs_n %0b sclk %0b din %0b rd_ack %0b",
				cs_n, sclk, din, rd_ack));
		phase = 0;
		for (int i = 0; i < num_ops; i++)
		begin
			if (op_phase[i] != phase)
			begin
				phase = op_phase[i];
				start_phase(phase);
			end
			host_read(op_channel[i], got_data, got_fresh);
			assert (got_data == op_data[i] && got_fresh == op_fresh[i])
			else
				report_mismatch($sformatf(
					"read %0d of channel %0d gave %03h fresh %0b, expected %03h fresh %0b",
					i, op_channel[i], got_data, got_fresh, op_data[i], op_fresh[i]));
		end
		check_address_order();
		$display("=== PASS ===");
		$finish;
	end

endmodule
